// ==== common/fetch_macros.svh ====
// reset vector, queue depth and fetch block size.
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset.
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// blocks held in the instruction queue.
// must be a power of two, at least 2.
`define IQ_DEPTH 4

// bytes per fetch block and its alignment.
`define BLOCK_BYTES 8

`endif

// ==== common/fetch_pkg.sv ====
// address, instruction, fetch block and instruction class types, rv opcodes.
`include "fetch_macros.svh"

package fetch_pkg;

	// byte address of an instruction or a fetch block.
	typedef logic [63:0] addr_t;

	// one uncompressed rv instruction.
	typedef logic [31:0] instr_t;

	// one memory beat, two instructions wide.
	typedef logic [`BLOCK_BYTES*8-1:0] block_t;

	// coarse class seen by the backend.
	typedef enum logic [2:0] {
		IC_ALU,
		IC_BRANCH,
		IC_JAL,
		IC_JALR,
		IC_SYSTEM
	} instr_class_e;

	// major opcodes the predecoder tells apart.
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage

// ==== rtl/pc_gen.sv ====
// fetch address register with sequential block step and redirect load.
`timescale 1ns/1ns
`include "fetch_macros.svh"

module pc_gen (
	input  logic             CLK,
	input  logic             rst,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  logic             fetch_ready,
	output fetch_pkg::addr_t fetch_pc
);

	// low address bits cleared by block alignment.
	localparam fetch_pkg::addr_t ALIGN_MASK = ~fetch_pkg::addr_t'(`BLOCK_BYTES - 1);

	fetch_pkg::addr_t pc_q;
	fetch_pkg::addr_t next_block_pc;

	// step from the aligned base.
	// an unaligned redirect target still lands on the following block.
	assign next_block_pc = (pc_q & ALIGN_MASK) + fetch_pkg::addr_t'(`BLOCK_BYTES);

	assign fetch_pc = pc_q;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc_q <= `FETCH_RESET_PC;
		end else if (redirect) begin
			// redirect wins over the step.
			pc_q <= redirect_pc;
		end else if (fetch_ready) begin
			// request went out this cycle.
			pc_q <= next_block_pc;
		end
	end

endmodule

// ==== ifetch/ifetch.sv ====
// single-outstanding fetch controller with boot, pending and output-valid state.
`timescale 1ns/1ns
`include "fetch_macros.svh"

module ifetch (
	input  logic              CLK,
	input  logic              rst,
	input  fetch_pkg::addr_t  fetch_pc,
	output logic              fetch_ready,
	output logic              mem_req_valid,
	output fetch_pkg::addr_t  mem_addr,
	input  logic              mem_rsp_valid,
	input  fetch_pkg::block_t mem_rsp_data,
	output logic              blk_valid,
	output fetch_pkg::addr_t  blk_pc,
	output fetch_pkg::block_t blk_data,
	input  logic              blk_ready,
	input  logic              redirect
);

	localparam fetch_pkg::addr_t ALIGN_MASK = ~fetch_pkg::addr_t'(`BLOCK_BYTES - 1);

	logic             boot;
	logic             pending;
	logic             stale;
	logic             rsp_take;
	fetch_pkg::addr_t req_pc;

	// boot kicks off a fresh path.
	// otherwise the next request rides on the block leaving.
	assign mem_req_valid = ~redirect & ~pending & (boot | (blk_valid & blk_ready));
	assign mem_addr = fetch_pc & ALIGN_MASK;
	assign fetch_ready = mem_req_valid;

	// response for the current path only.
	assign rsp_take = mem_rsp_valid & ~stale & ~redirect;

	always_ff @(posedge CLK) begin
		if (rst) begin
			boot      <= 1'b1;
			pending   <= 1'b0;
			stale     <= 1'b0;
			blk_valid <= 1'b0;
		end else begin
			if (redirect) begin
				boot <= 1'b1;
			end else if (mem_req_valid) begin
				boot <= 1'b0;
			end

			if (mem_req_valid) begin
				pending <= 1'b1;
			end else if (mem_rsp_valid) begin
				pending <= 1'b0;
			end

			// old path still in flight.
			if (mem_rsp_valid) begin
				stale <= 1'b0;
			end else if (redirect && pending) begin
				stale <= 1'b1;
			end

			// slot is always empty when a response lands.
			if (redirect) begin
				blk_valid <= 1'b0;
			end else if (rsp_take) begin
				blk_valid <= 1'b1;
			end else if (blk_ready) begin
				blk_valid <= 1'b0;
			end
		end
	end

	// unaligned pc kept so the queue can skip the low word.
	always_ff @(posedge CLK) begin
		if (mem_req_valid) begin
			req_pc <= fetch_pc;
		end
		if (rsp_take) begin
			blk_pc   <= req_pc;
			blk_data <= mem_rsp_data;
		end
	end

	// memory only answers what was asked.
	a_rsp_needs_req: assert property (@(posedge CLK) disable iff (rst)
		mem_rsp_valid |-> pending);

endmodule

// ==== iqueue/iqueue.sv ====
// fetch block fifo that hands out one instruction word at a time.
`timescale 1ns/1ns
`include "fetch_macros.svh"

module iqueue (
	input  logic              CLK,
	input  logic              rst,
	input  logic              blk_valid,
	input  fetch_pkg::addr_t  blk_pc,
	input  fetch_pkg::block_t blk_data,
	output logic              blk_ready,
	output logic              head_valid,
	output fetch_pkg::addr_t  head_pc,
	output fetch_pkg::instr_t head_instr,
	input  logic              head_pop,
	input  logic              redirect
);

	localparam int DEPTH = `IQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// block storage, no reset.
	fetch_pkg::addr_t  pc_mem [DEPTH];
	fetch_pkg::block_t data_mem [DEPTH];

	// extra msb tells full from empty.
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;

	// low word of head block already popped.
	logic half;

	logic              empty;
	logic              full;
	logic              push;
	logic              upper;
	fetch_pkg::addr_t  rd_pc;
	fetch_pkg::block_t rd_data;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	assign blk_ready = ~full;
	// a block arriving with the redirect belongs to the old path.
	assign push = blk_valid & ~full & ~redirect;

	assign rd_pc   = pc_mem[rd_ptr[PTR_W-1:0]];
	assign rd_data = data_mem[rd_ptr[PTR_W-1:0]];

	// pc bit 2 means entry at the high word.
	assign upper = half | rd_pc[2];

	assign head_valid = ~empty;
	assign head_pc    = {rd_pc[63:3], upper, 2'b00};
	assign head_instr = upper ? rd_data[32 +: 32] : rd_data[0 +: 32];

	always_ff @(posedge CLK) begin
		if (push) begin
			pc_mem[wr_ptr[PTR_W-1:0]]   <= blk_pc;
			data_mem[wr_ptr[PTR_W-1:0]] <= blk_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			half   <= 1'b0;
		end else if (redirect) begin
			// drop everything younger than the redirect.
			wr_ptr <= '0;
			rd_ptr <= '0;
			half   <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (head_pop) begin
				if (upper) begin
					// high word gone, free the block.
					rd_ptr <= rd_ptr + 1'b1;
					half   <= 1'b0;
				end else begin
					half <= 1'b1;
				end
			end
		end
	end

	// predecode only pops a valid head.
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (rst)
		head_pop |-> !empty);

endmodule

// ==== rtl/predecode.sv ====
// head instruction classification, jal target and issue/redirect drive.
`timescale 1ns/1ns

module predecode (
	input  logic                    head_valid,
	input  fetch_pkg::addr_t        head_pc,
	input  fetch_pkg::instr_t       head_instr,
	output logic                    head_pop,
	output logic                    issue_valid,
	output fetch_pkg::addr_t        issue_pc,
	output fetch_pkg::instr_t       issue_instr,
	output fetch_pkg::instr_class_e issue_class,
	input  logic                    issue_ready,
	output logic                    redirect,
	output fetch_pkg::addr_t        redirect_pc,
	input  logic                    CLK,
	input  logic                    rst
);

	logic [6:0]              opcode;
	fetch_pkg::instr_class_e cls;
	fetch_pkg::addr_t        j_imm;

	assign opcode = head_instr[6:0];

	// decode stage.
	always_comb begin
		case (opcode)
			fetch_pkg::OP_BRANCH: cls = fetch_pkg::IC_BRANCH;
			fetch_pkg::OP_JAL:    cls = fetch_pkg::IC_JAL;
			fetch_pkg::OP_JALR:   cls = fetch_pkg::IC_JALR;
			fetch_pkg::OP_SYSTEM: cls = fetch_pkg::IC_SYSTEM;
			default:              cls = fetch_pkg::IC_ALU;
		endcase
	end

	// j-type immediate, sign extended, bit 0 always zero.
	assign j_imm = {
		{44{head_instr[31]}},
		head_instr[19:12],
		head_instr[20],
		head_instr[30:21],
		1'b0
	};

	// issue straight from the queue head.
	assign issue_valid = head_valid;
	assign issue_pc    = head_pc;
	assign issue_instr = head_instr;
	assign issue_class = cls;

	assign head_pop = head_valid & issue_ready;

	// taken jal steers fetch.
	// branches fall through and only carry their class.
	assign redirect    = head_pop & (cls == fetch_pkg::IC_JAL);
	assign redirect_pc = head_pc + j_imm;

	// the queue empties behind a jal.
	// so the redirect is a single cycle pulse.
	a_redirect_pulse: assert property (@(posedge CLK) disable iff (rst)
		redirect |=> !redirect);

endmodule

// ==== rtl/frontend_top.sv ====
// fetch front end top with pc_gen, ifetch, iqueue, predecode and redirect merge.
`timescale 1ns/1ns

module frontend_top (
	input  logic                    CLK,
	input  logic                    rst,
	output logic                    mem_req_valid,
	output fetch_pkg::addr_t        mem_addr,
	input  logic                    mem_rsp_valid,
	input  fetch_pkg::block_t       mem_rsp_data,
	output logic                    issue_valid,
	output fetch_pkg::addr_t        issue_pc,
	output fetch_pkg::instr_t       issue_instr,
	output fetch_pkg::instr_class_e issue_class,
	input  logic                    issue_ready,
	input  logic                    flush,
	input  fetch_pkg::addr_t        flush_pc
);

	fetch_pkg::addr_t  fetch_pc;
	logic              fetch_ready;
	logic              blk_valid;
	fetch_pkg::addr_t  blk_pc;
	fetch_pkg::block_t blk_data;
	logic              blk_ready;
	logic              head_valid;
	fetch_pkg::addr_t  head_pc;
	fetch_pkg::instr_t head_instr;
	logic              head_pop;
	logic              pd_redirect;
	fetch_pkg::addr_t  pd_redirect_pc;
	logic              redirect;
	fetch_pkg::addr_t  redirect_pc;

	// backend flush beats a jal in the same cycle.
	assign redirect    = flush | pd_redirect;
	assign redirect_pc = flush ? flush_pc : pd_redirect_pc;

	pc_gen u_pc_gen (
		.CLK         (CLK),
		.rst         (rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_ready (fetch_ready),
		.fetch_pc    (fetch_pc)
	);

	ifetch u_ifetch (
		.CLK           (CLK),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.fetch_ready   (fetch_ready),
		.mem_req_valid (mem_req_valid),
		.mem_addr      (mem_addr),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data),
		.blk_valid     (blk_valid),
		.blk_pc        (blk_pc),
		.blk_data      (blk_data),
		.blk_ready     (blk_ready),
		.redirect      (redirect)
	);

	iqueue u_iqueue (
		.CLK        (CLK),
		.rst        (rst),
		.blk_valid  (blk_valid),
		.blk_pc     (blk_pc),
		.blk_data   (blk_data),
		.blk_ready  (blk_ready),
		.head_valid (head_valid),
		.head_pc    (head_pc),
		.head_instr (head_instr),
		.head_pop   (head_pop),
		.redirect   (redirect)
	);

	predecode u_predecode (
		.head_valid  (head_valid),
		.head_pc     (head_pc),
		.head_instr  (head_instr),
		.head_pop    (head_pop),
		.issue_valid (issue_valid),
		.issue_pc    (issue_pc),
		.issue_instr (issue_instr),
		.issue_class (issue_class),
		.issue_ready (issue_ready),
		.redirect    (pd_redirect),
		.redirect_pc (pd_redirect_pc),
		.CLK         (CLK),
		.rst         (rst)
	);

endmodule

// ==== verification/imem_model.sv ====
// behavioral instruction memory that answers each fetch one cycle later.
`timescale 1ns/1ns
`include "fetch_macros.svh"

module imem_model #(
	parameter fetch_pkg::addr_t BASE  = `FETCH_RESET_PC,
	parameter int               WORDS = 64
) (
	input  logic              CLK,
	input  logic              rst,
	input  logic              req_valid,
	input  fetch_pkg::addr_t  addr,
	output logic              rsp_valid,
	output fetch_pkg::block_t rsp_data
);

	// word storage, program words written in from the testbench.
	fetch_pkg::instr_t mem [WORDS];

	// addi x31 with an immediate folded from every address bit.
	function automatic fetch_pkg::instr_t fill_word(input fetch_pkg::addr_t a);
		logic [11:0] imm;
		imm = a[11:0] ^ a[23:12] ^ a[35:24] ^ a[47:36] ^ a[59:48] ^ {8'h00, a[63:60]};
		return {imm, 5'd0, 3'b000, 5'd31, 7'b0010011};
	endfunction

	// outside the array the fill pattern answers.
	function automatic fetch_pkg::instr_t read_word(input fetch_pkg::addr_t a);
		fetch_pkg::addr_t off;
		off = a - BASE;
		if (a >= BASE && off < fetch_pkg::addr_t'(WORDS * 4)) begin
			return mem[int'(off >> 2)];
		end
		return fill_word(a);
	endfunction

	initial begin
		rsp_valid = 1'b0;
		rsp_data  = '0;
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = fill_word(BASE + fetch_pkg::addr_t'(4 * i));
		end
	end

	// every request accepted, answered on the next edge.
	always @(posedge CLK) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= req_valid;
		end
		if (req_valid) begin
			// low word sits at the aligned address.
			rsp_data <= {read_word(addr + 64'd4), read_word(addr)};
		end
	end

endmodule

// ==== verification/tb_frontend.sv ====
// frontend testbench with program and expected issue tables, compare tasks and watchdog.
`timescale 1ns/1ns
`include "fetch_macros.svh"

module tb_frontend;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int N_PROG       = 9;
	localparam int N_STEPS      = 6;
	localparam int N_EXP        = 41;
	// 40 cycles per issue, plus a queue drain per step.
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * N_EXP + 4 * `IQ_DEPTH * N_STEPS;

	logic                    CLK;
	logic                    rst;
	logic                    mem_req_valid;
	fetch_pkg::addr_t        mem_addr;
	logic                    mem_rsp_valid;
	fetch_pkg::block_t       mem_rsp_data;
	logic                    issue_valid;
	fetch_pkg::addr_t        issue_pc;
	fetch_pkg::instr_t       issue_instr;
	fetch_pkg::instr_class_e issue_class;
	logic                    issue_ready;
	logic                    flush;
	fetch_pkg::addr_t        flush_pc;

	// offset from reset pc, word, class.
	// addi x1, addi x2, beq +16, addi x3, jal +0x20, addi x5, ecall, addi x6, jal -0x30.
	// 0x14 to 0x2c is never reached.
	int unsigned prog_off [N_PROG] = '{'h00, 'h04, 'h08, 'h0c, 'h10, 'h30, 'h34, 'h38, 'h3c};
	fetch_pkg::instr_t prog_word [N_PROG] = '{
		32'h00100093, 32'h00200113, 32'h00100863, 32'h00300193, 32'h0200006f,
		32'h00500293, 32'h00000073, 32'h00600313, 32'hfd1ff06f};
	fetch_pkg::instr_class_e prog_cls [N_PROG] = '{
		fetch_pkg::IC_ALU, fetch_pkg::IC_ALU, fetch_pkg::IC_BRANCH, fetch_pkg::IC_ALU,
		fetch_pkg::IC_JAL, fetch_pkg::IC_ALU, fetch_pkg::IC_SYSTEM, fetch_pkg::IC_ALU,
		fetch_pkg::IC_JAL};

	// test steps. a zero ready pattern means a random one.
	string step_name [N_STEPS] = '{"reset_seq", "flush_unaligned", "jal_fwd_back",
		"backpressure", "flush_pending", "branch_fall"};
	bit          step_flush [N_STEPS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
	bit          step_sync  [N_STEPS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	int unsigned step_start [N_STEPS] = '{'h00, 'h0c, 'h30, 'h00, 'h38, 'h08};
	logic [15:0] step_ready [N_STEPS] = '{16'hffff, 16'hffff, 16'hbeef, 16'h0000,
		16'hffff, 16'hffff};
	int          step_len   [N_STEPS] = '{12, 4, 7, 10, 5, 3};

	// expected issue offsets in address order, every jal taken, branches falling through.
	int unsigned exp_off [N_EXP] = '{
		'h00, 'h04, 'h08, 'h0c, 'h10, 'h30, 'h34, 'h38, 'h3c, 'h0c, 'h10, 'h30,
		'h0c, 'h10, 'h30, 'h34,
		'h30, 'h34, 'h38, 'h3c, 'h0c, 'h10, 'h30,
		'h00, 'h04, 'h08, 'h0c, 'h10, 'h30, 'h34, 'h38, 'h3c, 'h0c,
		'h38, 'h3c, 'h0c, 'h10, 'h30,
		'h08, 'h0c, 'h10};

	fetch_pkg::addr_t        got_pc [$];
	fetch_pkg::instr_t       got_instr [$];
	fetch_pkg::instr_class_e got_cls [$];

	int          exp_base;
	int          step_errs;
	int          total_errs;
	int          steps_failed;
	int          cyc;
	logic [15:0] pat;

	frontend_top dut (
		.CLK           (CLK),
		.rst           (rst),
		.mem_req_valid (mem_req_valid),
		.mem_addr      (mem_addr),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data),
		.issue_valid   (issue_valid),
		.issue_pc      (issue_pc),
		.issue_instr   (issue_instr),
		.issue_class   (issue_class),
		.issue_ready   (issue_ready),
		.flush         (flush),
		.flush_pc      (flush_pc)
	);

	imem_model imem (
		.CLK       (CLK),
		.rst       (rst),
		.req_valid (mem_req_valid),
		.addr      (mem_addr),
		.rsp_valid (mem_rsp_valid),
		.rsp_data  (mem_rsp_data)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// recorded half a cycle before the edge that takes it.
	always @(negedge CLK) begin
		if (!rst && issue_valid && issue_ready) begin
			got_pc.push_back(issue_pc);
			got_instr.push_back(issue_instr);
			got_cls.push_back(issue_class);
		end
	end

	function automatic fetch_pkg::instr_t word_at(input int unsigned off);
		fetch_pkg::instr_t w;
		w = '0;
		for (int i = 0; i < N_PROG; i++) begin
			if (prog_off[i] == off) begin
				w = prog_word[i];
			end
		end
		return w;
	endfunction

	function automatic fetch_pkg::instr_class_e class_at(input int unsigned off);
		fetch_pkg::instr_class_e c;
		c = fetch_pkg::IC_ALU;
		for (int i = 0; i < N_PROG; i++) begin
			if (prog_off[i] == off) begin
				c = prog_cls[i];
			end
		end
		return c;
	endfunction

	task automatic check_addr(input string tname, input int idx,
		input fetch_pkg::addr_t exp, input fetch_pkg::addr_t act);
		if (act !== exp) begin
			$display("ERR %s #%0d pc: expected %h, actual %h", tname, idx, exp, act);
			step_errs++;
		end
	endtask

	task automatic check_instr(input string tname, input int idx,
		input fetch_pkg::instr_t exp, input fetch_pkg::instr_t act);
		if (act !== exp) begin
			$display("ERR %s #%0d instr: expected %h, actual %h", tname, idx, exp, act);
			step_errs++;
		end
	endtask

	task automatic check_class(input string tname, input int idx,
		input fetch_pkg::instr_class_e exp, input fetch_pkg::instr_class_e act);
		if (act !== exp) begin
			$display("ERR %s #%0d class: expected %s, actual %s", tname, idx,
				exp.name(), act.name());
			step_errs++;
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < N_PROG; i++) begin
			imem.mem[prog_off[i] / 4] = prog_word[i];
		end
	endtask

	task automatic apply_step(input int s);
		if (step_flush[s]) begin
			if (step_sync[s]) begin
				// drain the queue until a request goes out.
				@(posedge CLK);
				issue_ready <= 1'b1;
				do @(negedge CLK); while (!mem_req_valid);
			end
			// flush lands in the cycle the response comes back.
			@(posedge CLK);
			flush       <= 1'b1;
			flush_pc    <= `FETCH_RESET_PC + fetch_pkg::addr_t'(step_start[s]);
			issue_ready <= 1'b0;
			got_pc.delete();
			got_instr.delete();
			got_cls.delete();
		end
		pat = step_ready[s];
		if (pat == 16'h0000) begin
			// long stall in the middle fills the queue.
			pat = (16'($urandom) & 16'hc00f) | 16'h0001;
		end
		cyc = 0;
		@(posedge CLK);
		flush <= 1'b0;
		while (got_pc.size() < step_len[s]) begin
			issue_ready <= pat[cyc[3:0]];
			cyc++;
			@(posedge CLK);
		end
		issue_ready <= 1'b0;
	endtask

	task automatic compare_step(input int s);
		int unsigned off;
		step_errs = 0;
		for (int i = 0; i < step_len[s]; i++) begin
			off = exp_off[exp_base + i];
			check_addr(step_name[s], i, `FETCH_RESET_PC + fetch_pkg::addr_t'(off), got_pc[i]);
			check_instr(step_name[s], i, word_at(off), got_instr[i]);
			check_class(step_name[s], i, class_at(off), got_cls[i]);
		end
		$display("test %s: %0d issued, %0d errors", step_name[s], step_len[s], step_errs);
		if (step_errs != 0) begin
			steps_failed++;
		end
		total_errs += step_errs;
		exp_base += step_len[s];
	endtask

	initial begin
		void'($urandom(32'h91b00945));
		rst          = 1'b1;
		flush        = 1'b0;
		flush_pc     = '0;
		issue_ready  = 1'b0;
		exp_base     = 0;
		total_errs   = 0;
		steps_failed = 0;
		@(negedge CLK);
		load_program();
		// first reset edge already passed.
		repeat (RESET_CYCLES - 1) @(posedge CLK);
		rst <= 1'b0;
		for (int s = 0; s < N_STEPS; s++) begin
			apply_step(s);
			compare_step(s);
		end
		$display("tests %0d, failed %0d, errors %0d", N_STEPS, steps_failed, total_errs);
		if (total_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("timeout: issue sequence not finished after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+common
common/fetch_pkg.sv
rtl/pc_gen.sv
ifetch/ifetch.sv
iqueue/iqueue.sv
rtl/predecode.sv
rtl/frontend_top.sv
verification/imem_model.sv
verification/tb_frontend.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend -f all.f -o sim_frontend
./obj_dir/sim_frontend > sim.log 2>&1
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
grep -q "Simulation PASSED" sim.log
